//--- rtos_core.f
logic/rtos_pkg.sv
logic/rtos_apb_cmd.sv
logic/rtos_task.sv
logic/rtos_semaphore.sv
logic/rtos_scheduler.sv
logic/rtos_core.sv
sim/rtos_core_tb.sv

//--- Makefile
# Verilator build and run of the RTOS scheduler core testbench.

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module rtos_core_tb -Mdir obj_dir -f rtos_core.f
	./obj_dir/Vrtos_core_tb

clean:
	rm -rf obj_dir

//--- sim/rtos_core_tb.sv
// Testbench for the hardware RTOS scheduler core.
// Builds tables of APB writes and status reads per scenario and applies them
// in a loop, checking each read against values worked out from the call rules.

`timescale 1ns/1ps
`default_nettype none

module rtos_core_tb;

    import rtos_pkg::*;

    localparam int APB_TIMEOUT = 8;
    localparam int POLL_CYCLES = 60;
    localparam logic [2:0] KIND_NONE = 3'd0;
    localparam logic [2:0] KIND_TSK  = 3'd1;
    localparam logic [2:0] KIND_RUN  = 3'd2;
    localparam logic [2:0] KIND_WORD = 3'd3;
    localparam logic [2:0] KIND_ERR  = 3'd4;

    // one table entry is either a register write or a read with its check.
    typedef struct packed {
        logic        wr_en;
        logic [7:0]  wr_addr;
        logic [31:0] wr_data;
        logic [2:0]  kind;
        logic [7:0]  rd_addr;
        logic [31:0] expected;
        logic        poll;
        logic [15:0] tmo;
    } step_t;

    logic                    clk;
    logic                    reset;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [7:0]              paddr;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pready;
    logic                    pslverr;
    logic                    run_valid;
    logic [TSKID_WIDTH-1:0]  run_tskid;
    logic [31:0]             lfsr_state;
    step_t                   steps [$];

    rtos_core u_rtos_core (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .run_valid, .run_tskid
    );

    always #20 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            fail_now($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            fail_now($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected));
        end
    endtask

    task automatic check_tskstat(input string name, input tskstat_t got, input tskstat_t expected);
        if (got !== expected) begin
            fail_now($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected));
        end
    endtask

    // the running id only means something while the valid bit is set.
    task automatic check_run(input logic got_valid, input logic [TSKID_WIDTH-1:0] got_id,
                             input logic exp_valid, input logic [TSKID_WIDTH-1:0] exp_id);
        check_flag("run_valid", got_valid, exp_valid);
        if (exp_valid && got_id !== exp_id) begin
            fail_now($sformatf("MISMATCH run_tskid: got 0x%0h, expected 0x%0h", got_id, exp_id));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1 in right-shifting Galois form.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] cmd_word(input opcode_t op, input int id);
        return 32'({id[1:0], op});
    endfunction

    function automatic logic [7:0] tsk_addr(input int id);
        return REG_TSK0 + 8'(4 * id);
    endfunction

    function automatic logic [31:0] run_word(input logic valid, input int id);
        return {29'b0, valid, id[1:0]};
    endfunction

    // one APB transfer: setup phase, access phase until pready, then idle.
    task automatic transfer(input logic write, input logic [7:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
        int waited;
        waited = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (pready !== 1'b1) begin
            if (waited == APB_TIMEOUT) begin
                fail_now("APB transfer never completed because pready stayed low");
            end
            @(negedge clk);
            #1;
            waited++;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        transfer(1'b1, addr, data, rdata, err);
        check_flag("pslverr", err, 1'b0);
    endtask

    task automatic add_write(input logic [7:0] addr, input logic [31:0] data);
        step_t s;
        s         = '0;
        s.wr_en   = 1'b1;
        s.wr_addr = addr;
        s.wr_data = data;
        s.kind    = KIND_NONE;
        steps.push_back(s);
    endtask

    task automatic add_check(input logic [2:0] kind, input logic [7:0] addr,
                             input logic [31:0] expected, input logic poll,
                             input int tmo = POLL_CYCLES);
        step_t s;
        s          = '0;
        s.kind     = kind;
        s.rd_addr  = addr;
        s.expected = expected;
        s.poll     = poll;
        s.tmo      = 16'(tmo);
        steps.push_back(s);
    endtask

    function automatic bit value_matches(input logic [2:0] kind, input logic [31:0] got,
                                         input logic [31:0] expected);
        case (kind)
            KIND_TSK: return got[3:0] === expected[3:0];
            KIND_RUN: return got[2] === expected[2] && (!expected[2] || got[1:0] === expected[1:0]);
            default:  return got === expected;
        endcase
    endfunction

    task automatic compare_step(input step_t s, input logic [31:0] got, input logic err);
        if (s.kind == KIND_ERR) begin
            check_flag("pslverr", err, 1'b1);
        end else begin
            check_flag("pslverr", err, 1'b0);
            case (s.kind)
                KIND_TSK: check_tskstat($sformatf("tskstat[%0d]", (s.rd_addr - REG_TSK0) >> 2),
                                        tskstat_t'(got[3:0]), tskstat_t'(s.expected[3:0]));
                KIND_RUN: begin
                    check_run(got[2], got[1:0], s.expected[2], s.expected[1:0]);
                    // the run pins come from the same registers as REG_RUN.
                    check_run(run_valid, run_tskid, s.expected[2], s.expected[1:0]);
                end
                default:  check_word($sformatf("reg 0x%02h", s.rd_addr), got, s.expected);
            endcase
        end
    endtask

    // a transfer takes three cycles, which is what a poll counts per read.
    task automatic run_table();
        step_t       s;
        logic [31:0] got;
        logic        err;
        int          cycles;
        foreach (steps[i]) begin
            s = steps[i];
            if (s.wr_en) begin
                write_reg(s.wr_addr, s.wr_data);
            end
            if (s.kind != KIND_NONE) begin
                transfer(1'b0, s.rd_addr, 32'b0, got, err);
                cycles = 3;
                while (s.poll && !value_matches(s.kind, got, s.expected)) begin
                    if (cycles > int'(s.tmo)) begin
                        fail_now($sformatf("timeout after %0d cycles polling register 0x%02h",
                                           cycles, s.rd_addr));
                    end
                    transfer(1'b0, s.rd_addr, 32'b0, got, err);
                    cycles += 3;
                end
                compare_step(s, got, err);
            end
        end
        steps.delete();
    endtask

    initial begin
        logic [31:0] ptn;
        logic [31:0] flags;
        logic [31:0] setbits;
        logic [31:0] mask;
        logic [31:0] dly;
        clk        = 1'b0;
        reset      = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lfsr_state = 32'd87272;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        // reset state, with each task's priority at 3 minus its id.
        check_run(run_valid, run_tskid, 1'b0, '0);
        for (int i = 0; i < TSK_NUM; i++) begin
            add_check(KIND_WORD, tsk_addr(i), 32'((TSK_NUM - 1 - i) << 4) | 32'(SLEEP), 1'b0);
        end
        add_check(KIND_RUN, REG_RUN, run_word(1'b0, 0), 1'b0);
        add_check(KIND_WORD, REG_FLG, 32'h0, 1'b0);
        add_check(KIND_WORD, REG_SEM, 32'h0, 1'b0);
        add_check(KIND_ERR, 8'h40, 32'h0, 1'b0);
        run_table();

        // task 2 outranks task 0 until it sleeps.
        add_write(REG_CMD, cmd_word(OP_WUP, 0));
        add_write(REG_CMD, cmd_word(OP_WUP, 2));
        add_check(KIND_TSK, tsk_addr(0), 32'(READY), 1'b1);
        add_check(KIND_TSK, tsk_addr(2), 32'(READY), 1'b1);
        add_check(KIND_RUN, REG_RUN, run_word(1'b1, 2), 1'b1);
        add_write(REG_CMD, cmd_word(OP_SLP, 2));
        add_check(KIND_TSK, tsk_addr(2), 32'(SLEEP), 1'b1);
        add_check(KIND_RUN, REG_RUN, run_word(1'b1, 0), 1'b1);
        run_table();

        // semaphore starts empty, so the first wait blocks.
        add_write(REG_CMD, cmd_word(OP_WAISEM, 1));
        add_check(KIND_TSK, tsk_addr(1), 32'(WAISEM), 1'b1);
        add_write(REG_CMD, cmd_word(OP_SIGSEM, 0));
        add_check(KIND_TSK, tsk_addr(1), 32'(READY), 1'b1);
        add_check(KIND_WORD, REG_SEM, 32'h0, 1'b0);
        add_write(REG_CMD, cmd_word(OP_SIGSEM, 0));
        add_write(REG_CMD, cmd_word(OP_SIGSEM, 0));
        add_check(KIND_WORD, REG_SEM, 32'h2, 1'b0);
        add_check(KIND_RUN, REG_RUN, run_word(1'b1, 1), 1'b1);
        run_table();

        // task 3 waits for every bit of its pattern.
        draw_bits(8, ptn);
        if (ptn == 0) begin
            ptn = 32'h01;
        end
        flags = 0;
        add_write(REG_FLGCLR, 32'h0);
        add_write(REG_ARG, ptn);
        add_write(REG_CMD, cmd_word(OP_WAIFLG, 3));
        add_check(KIND_TSK, tsk_addr(3), 32'(WAIFLG), 1'b0);
        for (int r = 0; r < 6; r++) begin
            draw_bits(8, setbits);
            draw_bits(8, mask);
            setbits = (r == 5) ? ptn : (setbits & mask);
            flags   = flags | setbits;
            add_write(REG_FLGSET, setbits);
            add_check(KIND_TSK, tsk_addr(3),
                      ((flags & ptn) == ptn) ? 32'(READY) : 32'(WAIFLG), 1'b0);
            if ((flags & ptn) == ptn) begin
                break;
            end
        end
        add_check(KIND_WORD, REG_FLG, flags, 1'b0);
        add_check(KIND_RUN, REG_RUN, run_word(1'b1, 3), 1'b1);
        run_table();

        // task 0 waits in OR mode and wakes on the first shared bit.
        draw_bits(8, ptn);
        if (ptn == 0) begin
            ptn = 32'h80;
        end
        flags = 0;
        add_write(REG_FLGCLR, 32'h0);
        add_check(KIND_WORD, REG_FLG, 32'h0, 1'b0);
        add_write(REG_ARG, 32'h1_0000 | ptn);
        add_write(REG_CMD, cmd_word(OP_WAIFLG, 0));
        add_check(KIND_TSK, tsk_addr(0), 32'(WAIFLG), 1'b0);
        for (int r = 0; r < 6; r++) begin
            draw_bits(8, setbits);
            draw_bits(8, mask);
            setbits = (r == 5) ? ptn : (setbits & mask);
            flags   = flags | setbits;
            add_write(REG_FLGSET, setbits);
            add_check(KIND_TSK, tsk_addr(0),
                      ((flags & ptn) != 0) ? 32'(READY) : 32'(WAIFLG), 1'b0);
            if ((flags & ptn) != 0) begin
                break;
            end
        end
        run_table();

        // a delay expires on its own, and release-wait cuts a long one short.
        draw_bits(8, dly);
        dly = dly + 4;
        add_write(REG_ARG, dly);
        add_write(REG_CMD, cmd_word(OP_DLY, 1));
        add_check(KIND_TSK, tsk_addr(1), 32'(DELAY), 1'b0);
        add_check(KIND_TSK, tsk_addr(1), 32'(READY), 1'b1, int'(2 * dly + 10));
        add_write(REG_ARG, 32'h0000_ffff);
        add_write(REG_CMD, cmd_word(OP_DLY, 1));
        add_check(KIND_TSK, tsk_addr(1), 32'(DELAY), 1'b0);
        add_write(REG_CMD, cmd_word(OP_RELWAI, 1));
        add_check(KIND_TSK, tsk_addr(1), 32'(READY), 1'b0);
        run_table();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/rtos_core.sv
// Top level of the hardware RTOS scheduler core.
// Joins the APB command stage, four task state machines, the semaphore
// and the scheduler.

`timescale 1ns/1ps
`default_nettype none

module rtos_core (
    input  wire logic                               clk,
    input  wire logic                               reset,
    input  wire logic                               psel,
    input  wire logic                               penable,
    input  wire logic                               pwrite,
    input  wire logic [7:0]                         paddr,
    input  wire logic [31:0]                        pwdata,
    output logic      [31:0]                        prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    output logic                                    run_valid,
    output logic      [rtos_pkg::TSKID_WIDTH-1:0]   run_tskid
);

    import rtos_pkg::*;

    tskstat_t                  tskstat [TSK_NUM];
    logic [TSKPRI_WIDTH-1:0]   tskpri [TSK_NUM];
    logic [TSK_NUM-1:0]        req_rdq;
    logic [TSK_NUM-1:0]        rdy_tsk;
    logic [TSK_NUM-1:0]        rdy_req;
    logic [TSK_NUM-1:0]        wup_tsk;
    logic [TSK_NUM-1:0]        slp_tsk;
    logic [TSK_NUM-1:0]        rel_wai;
    logic [TSK_NUM-1:0]        dly_tsk;
    logic [TSK_NUM-1:0]        wai_flg;
    logic [TSK_NUM-1:0]        wai_sem;
    logic [TSK_NUM-1:0]        rel_tsk;
    logic [RELTIM_WIDTH-1:0]   dly_tim;
    logic                      wai_flg_wfmode;
    logic [FLGPTN_WIDTH-1:0]   wai_flg_flgptn;
    logic [FLGPTN_WIDTH-1:0]   evtflg_flgptn;
    logic                      wai_sem_req;
    logic [TSKID_WIDTH-1:0]    wai_sem_tskid;
    logic                      sig_sem;
    logic [SEMCNT_WIDTH-1:0]   sem_cnt;

    rtos_apb_cmd u_apb_cmd (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .tskstat, .tskpri, .run_valid, .run_tskid, .sem_cnt,
        .rdy_req, .wup_tsk, .slp_tsk, .rel_wai, .dly_tsk, .wai_flg,
        .dly_tim, .wai_flg_wfmode, .wai_flg_flgptn,
        .wai_sem_req, .wai_sem_tskid, .sig_sem, .evtflg_flgptn
    );

    // a ready call takes the same path into REQRDY as a semaphore release.
    for (genvar i = 0; i < TSK_NUM; i++) begin : g_task
        rtos_task #(
            .TSKID (i)
        ) u_task (
            .clk, .reset,
            .rdy_tsk        (rdy_tsk[i]),
            .rel_tsk        (rel_tsk[i] | rdy_req[i]),
            .wup_tsk        (wup_tsk[i]),
            .slp_tsk        (slp_tsk[i]),
            .rel_wai        (rel_wai[i]),
            .dly_tsk        (dly_tsk[i]),
            .dly_tim,
            .wai_sem        (wai_sem[i]),
            .wai_flg        (wai_flg[i]),
            .wai_flg_wfmode, .wai_flg_flgptn, .evtflg_flgptn,
            .tskstat        (tskstat[i]),
            .tskpri         (tskpri[i]),
            .req_rdq        (req_rdq[i])
        );
    end

    rtos_semaphore u_semaphore (
        .clk, .reset, .wai_sem_req, .wai_sem_tskid, .sig_sem,
        .tskstat, .tskpri, .wai_sem, .rel_tsk, .sem_cnt
    );

    rtos_scheduler u_scheduler (
        .clk, .reset, .tskstat, .tskpri, .req_rdq,
        .rdy_tsk, .run_valid, .run_tskid
    );

endmodule

`default_nettype wire

//--- logic/rtos_scheduler.sv
// Scheduler stage of the RTOS core.
// Moves requesting tasks to READY and registers the highest-priority
// READY task as the running task.

`timescale 1ns/1ps
`default_nettype none

module rtos_scheduler (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  rtos_pkg::tskstat_t                       tskstat [rtos_pkg::TSK_NUM],
    input  wire logic [rtos_pkg::TSKPRI_WIDTH-1:0]   tskpri [rtos_pkg::TSK_NUM],
    input  wire logic [rtos_pkg::TSK_NUM-1:0]        req_rdq,
    output logic      [rtos_pkg::TSK_NUM-1:0]        rdy_tsk,
    output logic                                     run_valid,
    output logic      [rtos_pkg::TSKID_WIDTH-1:0]    run_tskid
);

    import rtos_pkg::*;

    logic                     sel_valid;
    logic [TSKID_WIDTH-1:0]   sel_id;
    logic [TSKPRI_WIDTH-1:0]  sel_pri;

    // every request is granted in the cycle it is seen.
    always_comb begin
        for (int i = 0; i < TSK_NUM; i++) begin
            rdy_tsk[i] = req_rdq[i] && tskstat[i] == REQRDY;
        end
    end

    // the smallest priority value wins, the lower id breaks a tie.
    always_comb begin
        sel_valid = 1'b0;
        sel_id    = '0;
        sel_pri   = '1;
        for (int i = TSK_NUM - 1; i >= 0; i--) begin
            if (tskstat[i] == READY && (!sel_valid || tskpri[i] <= sel_pri)) begin
                sel_valid = 1'b1;
                sel_id    = TSKID_WIDTH'(i);
                sel_pri   = tskpri[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            run_valid <= 1'b0;
            run_tskid <= '0;
        end else begin
            run_valid <= sel_valid;
            run_tskid <= sel_id;
        end
    end

endmodule

`default_nettype wire

//--- logic/rtos_semaphore.sv
// Counting semaphore of the RTOS core.
// Grants a wait while the count is nonzero and blocks the caller otherwise.
// A signal releases the best waiting task or raises the count.

`timescale 1ns/1ps
`default_nettype none

module rtos_semaphore (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                wai_sem_req,
    input  wire logic [rtos_pkg::TSKID_WIDTH-1:0]    wai_sem_tskid,
    input  wire logic                                sig_sem,
    input  rtos_pkg::tskstat_t                       tskstat [rtos_pkg::TSK_NUM],
    input  wire logic [rtos_pkg::TSKPRI_WIDTH-1:0]   tskpri [rtos_pkg::TSK_NUM],
    output logic      [rtos_pkg::TSK_NUM-1:0]        wai_sem,
    output logic      [rtos_pkg::TSK_NUM-1:0]        rel_tsk,
    output logic      [rtos_pkg::SEMCNT_WIDTH-1:0]   sem_cnt
);

    import rtos_pkg::*;

    logic                     wai_found;
    logic [TSKID_WIDTH-1:0]   wai_id;
    logic [TSKPRI_WIDTH-1:0]  wai_pri;

    // scanning downwards lets the lower id win a priority tie.
    always_comb begin
        wai_found = 1'b0;
        wai_id    = '0;
        wai_pri   = '1;
        for (int i = TSK_NUM - 1; i >= 0; i--) begin
            if (tskstat[i] == WAISEM && (!wai_found || tskpri[i] <= wai_pri)) begin
                wai_found = 1'b1;
                wai_id    = TSKID_WIDTH'(i);
                wai_pri   = tskpri[i];
            end
        end
    end

    assign wai_sem = (wai_sem_req && sem_cnt == '0) ? TSK_NUM'(1) << wai_sem_tskid : '0;
    assign rel_tsk = (sig_sem && wai_found) ? TSK_NUM'(1) << wai_id : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            sem_cnt <= '0;
        end else if (wai_sem_req && sem_cnt != '0) begin
            sem_cnt <= sem_cnt - 1'b1;
        end else if (sig_sem && !wai_found && sem_cnt != SEMCNT_WIDTH'(SEM_MAX)) begin
            sem_cnt <= sem_cnt + 1'b1;
        end
    end

    a_no_wrap_up: assert property (@(posedge clk) disable iff (reset)
        sem_cnt == SEMCNT_WIDTH'(SEM_MAX) |=> sem_cnt != '0);
    a_no_wrap_down: assert property (@(posedge clk) disable iff (reset)
        sem_cnt == '0 |=> sem_cnt != SEMCNT_WIDTH'(SEM_MAX));

endmodule

`default_nettype wire

//--- logic/rtos_task.sv
// Per-task state machine of the RTOS core.
// Tracks the task state, counts down delays and watches the event flags
// while the task waits on a pattern.

`timescale 1ns/1ps
`default_nettype none

module rtos_task #(
    parameter int TSKID = 0
) (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                rdy_tsk,
    input  wire logic                                rel_tsk,
    input  wire logic                                wup_tsk,
    input  wire logic                                slp_tsk,
    input  wire logic                                rel_wai,
    input  wire logic                                dly_tsk,
    input  wire logic [rtos_pkg::RELTIM_WIDTH-1:0]   dly_tim,
    input  wire logic                                wai_sem,
    input  wire logic                                wai_flg,
    input  wire logic                                wai_flg_wfmode,
    input  wire logic [rtos_pkg::FLGPTN_WIDTH-1:0]   wai_flg_flgptn,
    input  wire logic [rtos_pkg::FLGPTN_WIDTH-1:0]   evtflg_flgptn,
    output rtos_pkg::tskstat_t                       tskstat,
    output logic      [rtos_pkg::TSKPRI_WIDTH-1:0]   tskpri,
    output logic                                     req_rdq
);

    import rtos_pkg::*;

    // task 0 starts with the lowest rank, the last task with the highest.
    localparam logic [TSKPRI_WIDTH-1:0] INIT_TSKPRI = TSKPRI_WIDTH'(TSK_NUM - 1 - TSKID);

    tskstat_t                  next_tskstat;
    logic                      flg_wfmode;
    logic [FLGPTN_WIDTH-1:0]   flg_flgptn;
    logic [RELTIM_WIDTH-1:0]   dlytim;
    logic                      flg_match;
    logic                      waiting;

    assign tskpri = INIT_TSKPRI;

    // and mode needs every bit of the pattern, or mode needs any one of them.
    assign flg_match = flg_wfmode ? ((evtflg_flgptn & flg_flgptn) != '0)
                                  : ((evtflg_flgptn & flg_flgptn) == flg_flgptn);

    assign waiting = tskstat inside {DELAY, WAISEM, WAIFLG};

    always_comb begin
        next_tskstat = tskstat;
        if (tskstat == WAIFLG && flg_match) begin
            next_tskstat = REQRDY;
        end
        // the last count leaves the state, so a delay of d takes d cycles.
        if (tskstat == DELAY && dlytim <= RELTIM_WIDTH'(1)) begin
            next_tskstat = REQRDY;
        end

        if (rdy_tsk) begin
            next_tskstat = READY;
        end else if (rel_tsk || wup_tsk) begin
            next_tskstat = REQRDY;
        end else if (slp_tsk) begin
            next_tskstat = SLEEP;
        end else if (rel_wai && waiting) begin
            next_tskstat = REQRDY;
        end else if (dly_tsk) begin
            next_tskstat = DELAY;
        end else if (wai_sem) begin
            next_tskstat = WAISEM;
        end else if (wai_flg) begin
            next_tskstat = WAIFLG;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tskstat <= SLEEP;
            req_rdq <= 1'b0;
            dlytim  <= '0;
        end else begin
            tskstat <= next_tskstat;
            req_rdq <= (next_tskstat == REQRDY);
            if (dly_tsk) begin
                dlytim <= dly_tim;
            end else if (tskstat == DELAY && dlytim != '0) begin
                dlytim <= dlytim - 1'b1;
            end
        end
    end

    // the wait condition is captured along with the call.
    always_ff @(posedge clk) begin
        if (wai_flg) begin
            flg_wfmode <= wai_flg_wfmode;
            flg_flgptn <= wai_flg_flgptn;
        end
    end

    // the scheduler must only ready a task that asked for it.
    a_rdy_on_req: assert property (@(posedge clk) disable iff (reset)
        rdy_tsk |-> req_rdq);

endmodule

`default_nettype wire

//--- logic/rtos_apb_cmd.sv
// RTOS command stage behind an APB3 slave.
// Turns writes to the command register into one-cycle per-task strobes,
// keeps the argument and event-flag registers and serves status reads.

`timescale 1ns/1ps
`default_nettype none

module rtos_apb_cmd (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                psel,
    input  wire logic                                penable,
    input  wire logic                                pwrite,
    input  wire logic [7:0]                          paddr,
    input  wire logic [31:0]                         pwdata,
    output logic      [31:0]                         prdata,
    output logic                                     pready,
    output logic                                     pslverr,
    input  rtos_pkg::tskstat_t                       tskstat [rtos_pkg::TSK_NUM],
    input  wire logic [rtos_pkg::TSKPRI_WIDTH-1:0]   tskpri [rtos_pkg::TSK_NUM],
    input  wire logic                                run_valid,
    input  wire logic [rtos_pkg::TSKID_WIDTH-1:0]    run_tskid,
    input  wire logic [rtos_pkg::SEMCNT_WIDTH-1:0]   sem_cnt,
    output logic      [rtos_pkg::TSK_NUM-1:0]        rdy_req,
    output logic      [rtos_pkg::TSK_NUM-1:0]        wup_tsk,
    output logic      [rtos_pkg::TSK_NUM-1:0]        slp_tsk,
    output logic      [rtos_pkg::TSK_NUM-1:0]        rel_wai,
    output logic      [rtos_pkg::TSK_NUM-1:0]        dly_tsk,
    output logic      [rtos_pkg::TSK_NUM-1:0]        wai_flg,
    output logic      [rtos_pkg::RELTIM_WIDTH-1:0]   dly_tim,
    output logic                                     wai_flg_wfmode,
    output logic      [rtos_pkg::FLGPTN_WIDTH-1:0]   wai_flg_flgptn,
    output logic                                     wai_sem_req,
    output logic      [rtos_pkg::TSKID_WIDTH-1:0]    wai_sem_tskid,
    output logic                                     sig_sem,
    output logic      [rtos_pkg::FLGPTN_WIDTH-1:0]   evtflg_flgptn
);

    import rtos_pkg::*;

    logic                    acc;
    logic                    wr;
    logic                    tsk_hit;
    logic                    addr_hit;
    logic [TSKID_WIDTH-1:0]  tsk_idx;
    logic [TSKID_WIDTH-1:0]  cmd_tskid;
    logic [TSK_NUM-1:0]      cmd_sel;
    opcode_t                 cmd_op;
    logic [RELTIM_WIDTH:0]   arg_reg;

    assign acc       = psel && penable;
    assign wr        = acc && pwrite;
    assign cmd_op    = opcode_t'(pwdata[3:0]);
    assign cmd_tskid = pwdata[5:4];
    assign cmd_sel   = TSK_NUM'(1) << cmd_tskid;

    // task status words sit at REG_TSK0 plus four per task.
    assign tsk_hit  = (paddr >= REG_TSK0) && (paddr < REG_TSK0 + 8'(4 * TSK_NUM))
                      && (paddr[1:0] == 2'b00);
    assign tsk_idx  = TSKID_WIDTH'((paddr - REG_TSK0) >> 2);
    assign addr_hit = tsk_hit || paddr inside {REG_CMD, REG_ARG, REG_FLGSET, REG_FLGCLR,
                                                REG_FLG, REG_RUN, REG_SEM};

    assign pready  = 1'b1;
    assign pslverr = acc && !addr_hit;

    always_comb begin
        prdata = '0;
        if (tsk_hit) begin
            prdata = {24'b0, tskpri[tsk_idx], tskstat[tsk_idx]};
        end else begin
            case (paddr)
                REG_ARG: prdata = 32'(arg_reg);
                REG_FLG: prdata = 32'(evtflg_flgptn);
                REG_RUN: prdata = {29'b0, run_valid, run_tskid};
                REG_SEM: prdata = 32'(sem_cnt);
                default: prdata = '0;
            endcase
        end
    end

    // the argument is shared by every call that needs one.
    always_ff @(posedge clk) begin
        if (wr && paddr == REG_ARG) begin
            arg_reg <= pwdata[RELTIM_WIDTH:0];
        end
    end

    assign dly_tim        = arg_reg[RELTIM_WIDTH-1:0];
    assign wai_flg_flgptn = arg_reg[FLGPTN_WIDTH-1:0];
    assign wai_flg_wfmode = arg_reg[RELTIM_WIDTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            evtflg_flgptn <= '0;
        end else if (wr && paddr == REG_FLGSET) begin
            evtflg_flgptn <= evtflg_flgptn | pwdata[FLGPTN_WIDTH-1:0];
        end else if (wr && paddr == REG_FLGCLR) begin
            evtflg_flgptn <= evtflg_flgptn & pwdata[FLGPTN_WIDTH-1:0];
        end
    end

    // strobes live for exactly one cycle after the write.
    always_ff @(posedge clk) begin
        if (reset) begin
            rdy_req       <= '0;
            wup_tsk       <= '0;
            slp_tsk       <= '0;
            rel_wai       <= '0;
            dly_tsk       <= '0;
            wai_flg       <= '0;
            wai_sem_req   <= 1'b0;
            wai_sem_tskid <= '0;
            sig_sem       <= 1'b0;
        end else begin
            rdy_req     <= (wr && paddr == REG_CMD && cmd_op == OP_RDY)    ? cmd_sel : '0;
            wup_tsk     <= (wr && paddr == REG_CMD && cmd_op == OP_WUP)    ? cmd_sel : '0;
            slp_tsk     <= (wr && paddr == REG_CMD && cmd_op == OP_SLP)    ? cmd_sel : '0;
            rel_wai     <= (wr && paddr == REG_CMD && cmd_op == OP_RELWAI) ? cmd_sel : '0;
            dly_tsk     <= (wr && paddr == REG_CMD && cmd_op == OP_DLY)    ? cmd_sel : '0;
            wai_flg     <= (wr && paddr == REG_CMD && cmd_op == OP_WAIFLG) ? cmd_sel : '0;
            wai_sem_req <= wr && paddr == REG_CMD && cmd_op == OP_WAISEM;
            sig_sem     <= wr && paddr == REG_CMD && cmd_op == OP_SIGSEM;
            if (wr && paddr == REG_CMD) begin
                wai_sem_tskid <= cmd_tskid;
            end
        end
    end

    // the tasks and the semaphore rely on seeing one service call at a time.
    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        $onehot0({rdy_req, wup_tsk, slp_tsk, rel_wai, dly_tsk, wai_flg, wai_sem_req, sig_sem}));

endmodule

`default_nettype wire

//--- logic/rtos_pkg.sv
// RTOS scheduler core shared definitions.
// Holds the task-state and service-call encodings, the APB register map
// and the widths used across the core.

`default_nettype none

package rtos_pkg;

    localparam int TSK_NUM      = 4;
    localparam int TSKID_WIDTH  = 2;
    localparam int TSKPRI_WIDTH = 4;
    localparam int FLGPTN_WIDTH = 8;
    localparam int RELTIM_WIDTH = 16;
    localparam int SEMCNT_WIDTH = 4;
    localparam int SEM_MAX      = 15;

    // a lower priority value ranks higher.
    typedef enum logic [3:0] {
        SLEEP  = 4'h0,
        REQRDY = 4'h1,
        READY  = 4'h2,
        DELAY  = 4'h3,
        WAISEM = 4'h4,
        WAIFLG = 4'h5
    } tskstat_t;

    typedef enum logic [3:0] {
        OP_RDY    = 4'h0,
        OP_WUP    = 4'h1,
        OP_SLP    = 4'h2,
        OP_RELWAI = 4'h3,
        OP_DLY    = 4'h4,
        OP_WAISEM = 4'h5,
        OP_SIGSEM = 4'h6,
        OP_WAIFLG = 4'h7
    } opcode_t;

    localparam logic [7:0] REG_CMD    = 8'h00;
    localparam logic [7:0] REG_ARG    = 8'h04;
    localparam logic [7:0] REG_FLGSET = 8'h08;
    localparam logic [7:0] REG_FLGCLR = 8'h0C;
    localparam logic [7:0] REG_FLG    = 8'h10;
    localparam logic [7:0] REG_RUN    = 8'h14;
    localparam logic [7:0] REG_SEM    = 8'h18;
    localparam logic [7:0] REG_TSK0   = 8'h20;

endpackage

`default_nettype wire
